/* build.f */
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_bus_avalon.sv
verilog/lsu_result.sv
verilog/lsu_top.sv
test/lsu_asserts.sv
test/lsu_tb.sv

/* test/lsu_asserts.sv */
// Avalon-MM protocol checks on the load/store unit bridge
// Read/write exclusion, stability under waitrequest, burst count only from idle
`timescale 1ns/1ns

module lsu_asserts (
  input logic                            clk,
  input logic                            rst_n_i,
  input lsu_pkg::bus_state_e             state_q,           // Bridge state
  input logic [31:0]                     avm_address_o,
  input logic [3:0]                      avm_byteenable_o,
  input logic                            avm_read_o,
  input logic                            avm_write_o,
  input logic [31:0]                     avm_writedata_o,
  input logic [lsu_pkg::BURST_CNT_W-1:0] avm_burstcount_o,
  input logic                            avm_waitrequest_i
);

  int unsigned fail_cnt = 0;                                 // Assertion failures so far

  // A single access is either a read or a write
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(avm_read_o && avm_write_o))
    else begin
      fail_cnt++;
      $error("avm_read_o and avm_write_o are high in the same cycle");
    end

  // A stalled access keeps every field until the slave takes it
  a_hold_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
    ((avm_read_o || avm_write_o) && avm_waitrequest_i) |=>
      ($stable(avm_address_o) && $stable(avm_byteenable_o) && $stable(avm_writedata_o) &&
       $stable(avm_burstcount_o) && $stable(avm_read_o) && $stable(avm_write_o)))
    else begin
      fail_cnt++;
      $error("Avalon outputs changed while avm_waitrequest_i was high");
    end

  // Only the first beat announces the full burst
  a_burst_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    (avm_burstcount_o > 1) |-> (state_q == lsu_pkg::BUS_IDLE))
    else begin
      fail_cnt++;
      $error("avm_burstcount_o above 1 outside the idle state");
    end

endmodule

bind lsu_bus_avalon lsu_asserts u_asserts (
  .clk               (clk),
  .rst_n_i           (rst_n_i),
  .state_q           (state_q),
  .avm_address_o     (avm_address_o),
  .avm_byteenable_o  (avm_byteenable_o),
  .avm_read_o        (avm_read_o),
  .avm_write_o       (avm_write_o),
  .avm_writedata_o   (avm_writedata_o),
  .avm_burstcount_o  (avm_burstcount_o),
  .avm_waitrequest_i (avm_waitrequest_i)
);

/* test/lsu_tb.sv */
// Testbench of the load/store unit
// Avalon memory model with random stalls and read latency, shadow memory and reference
// Directed and random commands, response comparison, watchdog
`timescale 1ns/1ns

module lsu_tb;

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned RST_CYCLES = 10;
  localparam int unsigned RAND_CMDS  = 300;
  localparam int unsigned NUM_CMDS   = RAND_CMDS + 12;      // Random plus directed
  localparam int unsigned CMD_CYCLES = 1 + 3 + 1 + 4 + lsu_pkg::BURST_LEN + 3; // Worst case

  logic                            clk;
  logic                            rst_n_i;
  logic                            cmd_valid_i;
  lsu_pkg::lsu_cmd_t               cmd_i;
  logic                            busy_o;
  lsu_pkg::lsu_rsp_t               rsp_o;
  logic [31:0]                     avm_address_o;
  logic [3:0]                      avm_byteenable_o;
  logic                            avm_read_o;
  logic [31:0]                     avm_readdata_i;
  logic [lsu_pkg::BURST_CNT_W-1:0] avm_burstcount_o;
  logic                            avm_write_o;
  logic [31:0]                     avm_writedata_o;
  logic                            avm_waitrequest_i;
  logic                            avm_readdatavalid_i;

  logic [31:0]       mem [0:255];                            // Memory behind the Avalon port
  logic [31:0]       shadow [0:255];                         // What the memory should hold
  logic [31:0]       rd_q [$];                               // Read words not yet returned
  int unsigned       rd_delay;                               // Negedges until the first word
  lsu_pkg::lsu_rsp_t exp_q [$];                              // Responses still expected
  lsu_pkg::lsu_cmd_t cur_cmd;                                // Command in flight
  int unsigned       acc_cnt = 0;                            // Accesses taken by the memory
  int unsigned       rsp_cnt = 0;
  int unsigned       cmd_cnt = 0;
  int unsigned       err_cnt = 0;

  lsu_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Multiplicative hash so every address bit shows in the word
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx + 1) * 32'h9e37_79b1;
  endfunction

  function automatic lsu_pkg::lsu_cmd_t make_cmd(input lsu_pkg::lsu_op_e op,
                                                 input logic [31:0] addr,
                                                 input logic [31:0] wdata);
    return '{op: op, addr: addr, wdata: wdata};
  endfunction

  // Expected response data of one beat, from the shadow memory
  function automatic logic [31:0] lsu_expect(input lsu_pkg::lsu_op_e op,
                                             input logic [31:0] addr,
                                             input int unsigned beat);
    logic [7:0]  idx;
    logic [31:0] word;
    logic [7:0]  lane;
    idx  = addr[9:2] + beat[7:0];                            // Burst beats use consecutive words
    word = shadow[idx];
    lane = word[8*addr[1:0] +: 8];
    case (op)
      lsu_pkg::LSU_LW, lsu_pkg::LSU_LWB: return word;
      lsu_pkg::LSU_LB:                   return {{24{lane[7]}}, lane};
      lsu_pkg::LSU_LBU:                  return {24'd0, lane};
      default:                           return 32'd0;       // Stores answer with zero
    endcase
  endfunction

  task automatic shadow_store(input lsu_pkg::lsu_cmd_t cmd);
    if (cmd.op == lsu_pkg::LSU_SW) begin
      shadow[cmd.addr[9:2]] = cmd.wdata;
    end else if (cmd.op == lsu_pkg::LSU_SB) begin
      shadow[cmd.addr[9:2]][8*cmd.addr[1:0] +: 8] = cmd.wdata[7:0]; // Other lanes untouched
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // Called in the negedge where waitrequest goes low, so the DUT takes it at the next edge
  task automatic take_access();
    logic [7:0] idx;
    logic       exp_we;
    logic       is_byte;
    idx     = avm_address_o[9:2];
    is_byte = (cur_cmd.op == lsu_pkg::LSU_SB);
    exp_we  = is_byte || (cur_cmd.op == lsu_pkg::LSU_SW);
    acc_cnt++;
    check_value("avm_address_o", avm_address_o, {cur_cmd.addr[31:2], 2'b00});
    check_value("avm_write_o", avm_write_o, exp_we);
    check_value("avm_byteenable_o", avm_byteenable_o,
                is_byte ? (4'b0001 << cur_cmd.addr[1:0]) : 4'b1111);
    if (avm_write_o) begin
      check_value("avm_writedata_o", avm_writedata_o,
                  is_byte ? {4{cur_cmd.wdata[7:0]}} : cur_cmd.wdata);
      for (int l = 0; l < 4; l++) begin
        if (avm_byteenable_o[l]) begin
          mem[idx][8*l +: 8] = avm_writedata_o[8*l +: 8];
        end
      end
    end else begin
      check_value("avm_burstcount_o", avm_burstcount_o,
                  (cur_cmd.op == lsu_pkg::LSU_LWB) ? lsu_pkg::BURST_LEN : 1);
      for (int b = 0; b < avm_burstcount_o; b++) begin
        rd_q.push_back(mem[idx + b[7:0]]);
      end
      rd_delay = $urandom_range(4, 1);                       // Read latency in cycles
    end
  endtask

  initial begin : memory_model
    int unsigned wait_left;
    bit          stalled;
    wait_left           = 0;
    stalled             = 1'b0;
    rd_delay            = 0;
    avm_readdata_i      = 32'd0;
    avm_waitrequest_i   = 1'b0;
    avm_readdatavalid_i = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      avm_readdatavalid_i = 1'b0;
      avm_readdata_i      = $urandom();                      // Noise between valid beats
      if (rd_q.size() > 0) begin
        if (rd_delay > 0) begin
          rd_delay--;
        end
        if (rd_delay == 0) begin
          avm_readdatavalid_i = 1'b1;
          avm_readdata_i      = rd_q.pop_front();
        end
      end
      avm_waitrequest_i = 1'b0;
      if (avm_read_o || avm_write_o) begin
        if (!stalled) begin
          stalled   = 1'b1;
          wait_left = $urandom_range(3, 0);                  // Stall cycles of this access
        end
        if (wait_left > 0) begin
          avm_waitrequest_i = 1'b1;
          wait_left--;
        end else begin
          stalled = 1'b0;
          take_access();
        end
      end
    end
  end

  // Outputs are sampled at the rising edge where they are settled
  always @(posedge clk) begin : compare_responses
    lsu_pkg::lsu_rsp_t exp_rsp;
    if (rst_n_i && rsp_o.valid) begin
      rsp_cnt++;
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("Response with data 0x%08h arrived when none was expected", rsp_o.data);
      end
      if (exp_q.size() > 0) begin
        exp_rsp = exp_q.pop_front();
        check_value("rsp_o.data", rsp_o.data, exp_rsp.data);
        check_value("rsp_o.last", rsp_o.last, exp_rsp.last);
      end
    end
  end

  task automatic check_idle();
    check_value("avm_read_o", avm_read_o, 0);
    check_value("avm_write_o", avm_write_o, 0);
    check_value("busy_o", busy_o, 0);
    check_value("rsp_o.valid", rsp_o.valid, 0);
  endtask

  // Issues one command at a negedge and returns at the negedge after busy falls
  task automatic run_cmd(input lsu_pkg::lsu_cmd_t cmd, input bit poke_busy);
    int unsigned       beats;
    int unsigned       acc_start;
    int unsigned       rsp_start;
    lsu_pkg::lsu_rsp_t exp_rsp;
    beats = (cmd.op == lsu_pkg::LSU_LWB) ? lsu_pkg::BURST_LEN : 1;
    for (int b = 0; b < beats; b++) begin
      exp_rsp = '{valid: 1'b1, last: (b == beats - 1), data: lsu_expect(cmd.op, cmd.addr, b)};
      exp_q.push_back(exp_rsp);
    end
    shadow_store(cmd);
    cur_cmd     = cmd;
    acc_start   = acc_cnt;
    rsp_start   = rsp_cnt;
    cmd_i       = cmd;
    cmd_valid_i = 1'b1;
    @(negedge clk);
    cmd_valid_i = 1'b0;
    assert (busy_o) else begin
      err_cnt++;
      $display("busy_o did not rise one cycle after the command was accepted");
    end
    if (poke_busy) begin
      cmd_i       = make_cmd(lsu_pkg::LSU_SW, ~cmd.addr, $urandom()); // Must be dropped
      cmd_valid_i = 1'b1;
      @(negedge clk);
      cmd_valid_i = 1'b0;
    end
    while (busy_o) begin
      @(negedge clk);
    end
    assert (acc_cnt - acc_start == 1) else begin
      err_cnt++;
      $display("Command %0d made %0d Avalon accesses instead of one", cmd_cnt,
               acc_cnt - acc_start);
    end
    assert (rsp_cnt - rsp_start == beats) else begin
      err_cnt++;
      $display("Command %0d gave %0d responses instead of %0d", cmd_cnt,
               rsp_cnt - rsp_start, beats);
    end
    cmd_cnt++;
  endtask

  function automatic lsu_pkg::lsu_cmd_t random_cmd();
    lsu_pkg::lsu_cmd_t cmd;
    cmd.op    = lsu_pkg::lsu_op_e'($urandom_range(5, 0));
    cmd.addr  = $urandom_range(1023, 0);
    cmd.wdata = $urandom();
    if (cmd.op == lsu_pkg::LSU_LWB) begin
      cmd.addr[3:0] = 4'd0;                                  // Bursts start on 16 bytes
    end
    return cmd;
  endfunction

  initial begin : stimulus
    void'($urandom(32'h85b3_2eca));
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    repeat (RST_CYCLES) @(negedge clk);
    check_idle();
    rst_n_i = 1'b1;
    @(negedge clk);
    check_idle();
    run_cmd(make_cmd(lsu_pkg::LSU_SW, 32'h0000_0040, 32'hdead_beef), 1'b1);
    run_cmd(make_cmd(lsu_pkg::LSU_LW, 32'h0000_0040, 32'h0), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_SB, 32'h0000_0045, 32'h1234_56a5), 1'b1);
    run_cmd(make_cmd(lsu_pkg::LSU_SB, 32'h0000_0047, 32'h0000_0071), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_LW, 32'h0000_0044, 32'h0), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_LB, 32'h0000_0043, 32'h0), 1'b0);  // Byte 0xde has its top bit set
    run_cmd(make_cmd(lsu_pkg::LSU_LBU, 32'h0000_0043, 32'h0), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_LB, 32'h0000_0045, 32'h0), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_LBU, 32'h0000_0045, 32'h0), 1'b1);
    run_cmd(make_cmd(lsu_pkg::LSU_LB, 32'h0000_0047, 32'h0), 1'b0);  // Positive byte
    run_cmd(make_cmd(lsu_pkg::LSU_LWB, 32'h0000_0040, 32'h0), 1'b0);
    run_cmd(make_cmd(lsu_pkg::LSU_LWB, 32'h0000_0080, 32'h0), 1'b1);
    for (int n = 0; n < RAND_CMDS; n++) begin
      run_cmd(random_cmd(), ($urandom_range(3, 0) == 0));
    end
    repeat (4) @(negedge clk);                               // Room for any stray response
    check_idle();
    $display("Commands %0d, responses %0d, check errors %0d, assertion errors %0d",
             cmd_cnt, rsp_cnt, err_cnt, UUT.u_bus.u_asserts.fail_cnt);
    if (err_cnt == 0 && UUT.u_bus.u_asserts.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(CLK_PERIOD * (RST_CYCLES + 2 * NUM_CMDS * CMD_CYCLES));
    $display("Watchdog expired after %0d commands, the DUT stopped answering", cmd_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* verilog/lsu_bus_avalon.sv */
// Avalon-MM bridge of the load/store unit
// Four-state machine for single read, burst read and write
// Request fields go straight to the Avalon outputs and acks come back per beat
`timescale 1ns/1ns

module lsu_bus_avalon (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  lsu_pkg::cpu_req_t               cpu_req_i,          // Request from decode
  output lsu_pkg::cpu_rsp_t               cpu_rsp_o,          // Ack and read data
  output logic [31:0]                     avm_address_o,
  output logic [3:0]                      avm_byteenable_o,
  output logic                            avm_read_o,
  input  logic [31:0]                     avm_readdata_i,
  output logic [lsu_pkg::BURST_CNT_W-1:0] avm_burstcount_o,
  output logic                            avm_write_o,
  output logic [31:0]                     avm_writedata_o,
  input  logic                            avm_waitrequest_i,
  input  logic                            avm_readdatavalid_i
);

  lsu_pkg::bus_state_e state_q;                              // Current bridge state
  lsu_pkg::bus_state_e state_d;                              // Next bridge state
  logic                in_idle;                              // Accesses start only here

  assign in_idle = (state_q == lsu_pkg::BUS_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::BUS_IDLE: begin
        // Leave idle only once the slave has taken the access
        if (cpu_req_i.req && !avm_waitrequest_i) begin
          if (cpu_req_i.we) begin
            state_d = lsu_pkg::BUS_WRITE;
          end else if (cpu_req_i.burst) begin
            state_d = lsu_pkg::BUS_BURST;
          end else begin
            state_d = lsu_pkg::BUS_READ;
          end
        end
      end
      lsu_pkg::BUS_READ: begin
        if (avm_readdatavalid_i) begin
          state_d = lsu_pkg::BUS_IDLE;                       // Single beat returned
        end
      end
      lsu_pkg::BUS_BURST: begin
        // Burst is low during the last beat so this valid closes the burst
        if (!cpu_req_i.burst && avm_readdatavalid_i) begin
          state_d = lsu_pkg::BUS_IDLE;
        end
      end
      lsu_pkg::BUS_WRITE: begin
        state_d = lsu_pkg::BUS_IDLE;                         // Write ack takes one cycle
      end
      default: begin
        state_d = lsu_pkg::BUS_IDLE;                         // Recover from an illegal code
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= lsu_pkg::BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Strobes are qualified by idle and the rest comes straight from the request
  assign avm_address_o    = cpu_req_i.adr;
  assign avm_byteenable_o = cpu_req_i.bsel;
  assign avm_writedata_o  = cpu_req_i.dat;
  assign avm_read_o       = cpu_req_i.req & ~cpu_req_i.we & in_idle;
  assign avm_write_o      = cpu_req_i.req & cpu_req_i.we & in_idle;

  // The full burst length is only announced on the first beat
  assign avm_burstcount_o = (cpu_req_i.burst && (state_q != lsu_pkg::BUS_BURST)) ?
                            lsu_pkg::BURST_LEN :
                            {{(lsu_pkg::BURST_CNT_W-1){1'b0}}, 1'b1};

  assign cpu_rsp_o = '{
    ack: avm_readdatavalid_i | (state_q == lsu_pkg::BUS_WRITE),
    dat: avm_readdata_i
  };

endmodule

/* verilog/lsu_decode.sv */
// Command decode of the load/store unit
// Latches an accepted command, builds the processor-side bus request,
// counts the beats still owed and drives busy
`timescale 1ns/1ns

module lsu_decode (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              cmd_valid_i,                     // Command strobe
  input  lsu_pkg::lsu_cmd_t cmd_i,                           // Command fields
  input  lsu_pkg::cpu_rsp_t cpu_rsp_i,                       // Ack from the bridge
  output lsu_pkg::cpu_req_t cpu_req_o,                       // Request to the bridge
  output lsu_pkg::lsu_ctx_t ctx_o,                           // Context for the result block
  output logic              busy_o                           // Level while a command is open
);

  lsu_pkg::lsu_cmd_t                cmd_q;                   // Command in flight
  logic                             busy_q;                  // Set the cycle after acceptance
  logic [lsu_pkg::BURST_CNT_W-1:0]  beat_cnt_q;              // Acks still owed
  logic                             accept;                  // Strobe taken this cycle
  logic                             final_beat;              // Next ack is the last one
  logic                             is_store;                // Write opcode in flight
  logic [3:0]                       bsel;                    // Lane selects of the request
  logic [31:0]                      wdat;                    // Store data of the request

  assign accept = cmd_valid_i & ~busy_q;                     // Strobes while busy are dropped

  // Counter value 1 means only the final beat remains
  assign final_beat = busy_q &
                      (beat_cnt_q == {{(lsu_pkg::BURST_CNT_W-1){1'b0}}, 1'b1});

  // The command only changes on acceptance so the request is steady under waitrequest
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;                                        // Busy one cycle after acceptance
      if (cmd_i.op == lsu_pkg::LSU_LWB) begin
        beat_cnt_q <= lsu_pkg::BURST_LEN;                    // A burst owes BURST_LEN acks
      end else begin
        beat_cnt_q <= {{(lsu_pkg::BURST_CNT_W-1){1'b0}}, 1'b1}; // Everything else owes one
      end
    end else if (busy_q && cpu_rsp_i.ack) begin
      beat_cnt_q <= beat_cnt_q - 1'b1;                       // One beat done
      if (final_beat) begin
        busy_q <= 1'b0;                                      // Released by the final ack
      end
    end
  end

  // Byte stores select one lane and copy the byte to every lane
  always_comb begin
    bsel = 4'b1111;                                          // Word accesses use all lanes
    wdat = cmd_q.wdata;
    if (cmd_q.op == lsu_pkg::LSU_SB) begin
      bsel = 4'b0001 << cmd_q.addr[1:0];                     // One-hot at the byte offset
      wdat = {4{cmd_q.wdata[7:0]}};
    end
  end

  assign is_store = (cmd_q.op == lsu_pkg::LSU_SW) | (cmd_q.op == lsu_pkg::LSU_SB);

  // Burst stays high until the last beat starts, then the bridge leaves BUS_BURST
  assign cpu_req_o = '{
    req:   busy_q,
    we:    busy_q & is_store,
    burst: busy_q & ~final_beat,
    bsel:  bsel,
    adr:   {cmd_q.addr[31:2], 2'b00},                        // Bits 1:0 are ignored
    dat:   wdat
  };

  assign ctx_o = '{
    op:       cmd_q.op,
    offset:   cmd_q.addr[1:0],
    is_final: final_beat
  };

  assign busy_o = busy_q;

endmodule

/* verilog/lsu_pkg.sv */
// Shared definitions of the load/store unit
// Burst parameters, opcode and bridge state enums
// Packed structs for the command, the bus request and answer, the context and the response
package lsu_pkg;

  localparam int unsigned BURST_CNT_W = 4;                   // Width of the Avalon burstcount
  localparam logic [BURST_CNT_W-1:0] BURST_LEN = 4;          // Beats in one burst load

  // Opcodes carried by the command strobe
  typedef enum logic [2:0] {
    LSU_LW  = 3'd0,                                          // Load word
    LSU_LB  = 3'd1,                                          // Load byte with sign extension
    LSU_LBU = 3'd2,                                          // Load byte with zero extension
    LSU_SW  = 3'd3,                                          // Store word
    LSU_SB  = 3'd4,                                          // Store byte
    LSU_LWB = 3'd5                                           // Burst load of BURST_LEN words
  } lsu_op_e;

  // One-hot state of the Avalon bridge
  typedef enum logic [3:0] {
    BUS_IDLE  = 4'b0001,                                     // Free to start an access
    BUS_READ  = 4'b0010,                                     // Waiting for a single read beat
    BUS_BURST = 4'b0100,                                     // Collecting burst read beats
    BUS_WRITE = 4'b1000                                      // Write accepted and acked here
  } bus_state_e;

  // Command as it arrives with cmd_valid_i
  typedef struct packed {
    lsu_op_e     op;                                         // Operation to perform
    logic [31:0] addr;                                       // Byte address
    logic [31:0] wdata;                                      // Store data in the low lanes
  } lsu_cmd_t;

  // Processor-side bus request from decode to the bridge
  typedef struct packed {
    logic        req;                                        // Held until the ending ack
    logic        we;                                         // Write when set
    logic        burst;                                      // Falls when the last beat starts
    logic [3:0]  bsel;                                       // Byte lane selects
    logic [31:0] adr;                                        // Word aligned address
    logic [31:0] dat;                                        // Lane replicated store data
  } cpu_req_t;

  // Answer of the bridge
  typedef struct packed {
    logic        ack;                                        // One pulse per completed beat
    logic [31:0] dat;                                        // Read data of the beat
  } cpu_rsp_t;

  // Context of the command in flight
  typedef struct packed {
    lsu_op_e     op;                                         // Opcode that picks the extension
    logic [1:0]  offset;                                     // Byte offset inside the word
    logic        is_final;                                   // Next ack ends the command
  } lsu_ctx_t;

  // Response returned to the core
  typedef struct packed {
    logic        valid;                                      // One cycle per beat
    logic        last;                                       // Marks the command's final beat
    logic [31:0] data;                                       // Extended load data or zero
  } lsu_rsp_t;

endpackage

/* verilog/lsu_result.sv */
// Result formatting of the load/store unit
// Byte lane select with sign or zero extension
// Response pulse with the last-beat flag
`timescale 1ns/1ns

module lsu_result (
  input  lsu_pkg::cpu_rsp_t cpu_rsp_i,                       // Ack and read data
  input  lsu_pkg::lsu_ctx_t ctx_i,                           // Command in flight
  output lsu_pkg::lsu_rsp_t rsp_o                            // Response to the core
);

  logic [7:0]  lane;                                         // Addressed byte of the word
  logic        sign;                                         // Extension bit for LSU_LB
  logic [31:0] load_data;                                    // Formatted response data

  // Little endian lanes so offset 0 is the low byte
  always_comb begin
    case (ctx_i.offset)
      2'd0: begin
        lane = cpu_rsp_i.dat[7:0];
      end
      2'd1: begin
        lane = cpu_rsp_i.dat[15:8];
      end
      2'd2: begin
        lane = cpu_rsp_i.dat[23:16];
      end
      default: begin
        lane = cpu_rsp_i.dat[31:24];
      end
    endcase
  end

  assign sign = lane[7];                                     // Top bit of the selected byte

  always_comb begin
    case (ctx_i.op)
      lsu_pkg::LSU_LB: begin
        load_data = {{24{sign}}, lane};                      // Sign extended byte
      end
      lsu_pkg::LSU_LBU: begin
        load_data = {24'd0, lane};                           // Zero extended byte
      end
      lsu_pkg::LSU_LW, lsu_pkg::LSU_LWB: begin
        load_data = cpu_rsp_i.dat;                           // Whole word passes through
      end
      default: begin
        load_data = 32'd0;                                   // Stores answer with zero
      end
    endcase
  end

  // Purely combinational so the response lands in the ack cycle
  assign rsp_o = '{
    valid: cpu_rsp_i.ack,
    last:  cpu_rsp_i.ack & ctx_i.is_final,
    data:  load_data
  };

endmodule

/* verilog/lsu_top.sv */
// Top level of the load/store unit
// Connects decode, the Avalon bridge and result formatting
`timescale 1ns/1ns

module lsu_top (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            cmd_valid_i,       // Command strobe
  input  lsu_pkg::lsu_cmd_t               cmd_i,             // Opcode, address and store data
  output logic                            busy_o,            // Command in progress
  output lsu_pkg::lsu_rsp_t               rsp_o,             // Per-beat response
  output logic [31:0]                     avm_address_o,
  output logic [3:0]                      avm_byteenable_o,
  output logic                            avm_read_o,
  input  logic [31:0]                     avm_readdata_i,
  output logic [lsu_pkg::BURST_CNT_W-1:0] avm_burstcount_o,
  output logic                            avm_write_o,
  output logic [31:0]                     avm_writedata_o,
  input  logic                            avm_waitrequest_i,
  input  logic                            avm_readdatavalid_i
);

  lsu_pkg::cpu_req_t cpu_req;                                // Decode to bridge
  lsu_pkg::cpu_rsp_t cpu_rsp;                                // Bridge to decode and result
  lsu_pkg::lsu_ctx_t ctx;                                    // Decode to result

  lsu_decode u_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cpu_rsp_i   (cpu_rsp),
    .cpu_req_o   (cpu_req),
    .ctx_o       (ctx),
    .busy_o      (busy_o)
  );

  lsu_bus_avalon u_bus (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .cpu_req_i           (cpu_req),
    .cpu_rsp_o           (cpu_rsp),
    .avm_address_o       (avm_address_o),
    .avm_byteenable_o    (avm_byteenable_o),
    .avm_read_o          (avm_read_o),
    .avm_readdata_i      (avm_readdata_i),
    .avm_burstcount_o    (avm_burstcount_o),
    .avm_write_o         (avm_write_o),
    .avm_writedata_o     (avm_writedata_o),
    .avm_waitrequest_i   (avm_waitrequest_i),
    .avm_readdatavalid_i (avm_readdatavalid_i)
  );

  lsu_result u_result (
    .cpu_rsp_i (cpu_rsp),
    .ctx_i     (ctx),
    .rsp_o     (rsp_o)
  );

endmodule
